// File: design/bridge_pkg.sv
package bridge_pkg;

  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int LINE_WORDS = 4;
  localparam int STRB_W     = 4;

  typedef logic [2:0] req_type_t;

  localparam req_type_t TYPE_BYTE = 3'd0;
  localparam req_type_t TYPE_HALF = 3'd1;
  localparam req_type_t TYPE_WORD = 3'd2;
  localparam req_type_t TYPE_LINE = 3'd4;

  localparam logic [3:0] ID_INST = 4'd0;
  localparam logic [3:0] ID_DATA = 4'd1;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    req_type_t         rtype;
  } rd_req_t;

  // word 0 sits in the top bits and is data[0]
  typedef struct packed {
    logic [ADDR_W-1:0]                      addr;
    req_type_t                              rtype;
    logic [STRB_W-1:0]                      strb;
    logic [0:LINE_WORDS-1][DATA_W-1:0]      data;
  } wr_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } ret_t;

  typedef struct packed {
    logic [3:0]        id;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
  } axi_ar_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
  } axi_aw_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } axi_w_t;

  typedef struct packed {
    logic [3:0]        id;
    logic [DATA_W-1:0] data;
    logic              last;
  } axi_r_t;

  // a line is four beats, everything else is one
  function automatic logic [7:0] burst_len(req_type_t rtype);
    return (rtype == TYPE_LINE) ? 8'd3 : 8'd0;
  endfunction

  function automatic logic [2:0] burst_size(req_type_t rtype);
    logic [2:0] size;
    case (rtype)
      TYPE_BYTE: size = 3'd0;
      TYPE_HALF: size = 3'd1;
      default:   size = 3'd2;
    endcase
    return size;
  endfunction

endpackage

// File: design/req_slot.sv
module req_slot #(
  parameter type payload_t = logic
) (
  input  logic     aclk,
  input  logic     reset,
  input  logic     load,
  input  payload_t load_data,
  input  logic     ready,
  output logic     valid,
  output payload_t data
);

  always_ff @(posedge aclk) begin
    if (reset) begin
      valid <= 1'b0;
    end else if (load) begin
      valid <= 1'b1;
    end else if (valid && ready) begin
      valid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (load) begin
      data <= load_data;
    end
  end

  // upstream must not reload while the slot is still waiting on ready
  payload_stable: assert property (
    @(posedge aclk) disable iff (reset)
    valid && !ready |=> $stable(data)
  );

endmodule

// File: design/read_arbiter.sv
module read_arbiter (
  input  logic                aclk,
  input  logic                reset,
  input  logic                inst_rd_req,
  input  logic                data_rd_req,
  input  bridge_pkg::rd_req_t inst_rd,
  input  bridge_pkg::rd_req_t data_rd,
  output logic                inst_rd_rdy,
  output logic                data_rd_rdy,
  input  logic                write_busy,
  input  logic                slot_full,
  output logic                ar_load,
  output bridge_pkg::axi_ar_t ar_data,
  input  logic                rvalid,
  input  bridge_pkg::axi_r_t  r,
  output logic                inst_ret_valid,
  output logic                data_ret_valid,
  output bridge_pkg::ret_t    inst_ret,
  output bridge_pkg::ret_t    data_ret
);
  import bridge_pkg::*;

  logic       inst_out_q;
  logic       data_out_q;
  logic       inst_gnt;
  logic       data_gnt;
  logic [1:0] gnt_q;
  rd_req_t    win;
  ret_t       beat;

  // data reads also hold off behind a pending write
  assign data_rd_rdy = !data_out_q && !slot_full && !write_busy;
  assign data_gnt    = data_rd_req && data_rd_rdy;

  // data wins a same-cycle tie
  assign inst_rd_rdy = !inst_out_q && !slot_full && !data_gnt;
  assign inst_gnt    = inst_rd_req && inst_rd_rdy;

  assign ar_load = inst_gnt || data_gnt;
  assign win     = data_gnt ? data_rd : inst_rd;

  always_comb begin
    ar_data.id   = data_gnt ? ID_DATA : ID_INST;
    ar_data.addr = win.addr;
    ar_data.len  = burst_len(win.rtype);
    ar_data.size = burst_size(win.rtype);
  end

  // owner of the AR slot, one bit per port
  always_ff @(posedge aclk) begin
    if (reset) begin
      gnt_q <= 2'b00;
    end else if (ar_load) begin
      gnt_q <= {data_gnt, inst_gnt};
    end else if (!slot_full) begin
      gnt_q <= 2'b00;
    end
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      inst_out_q <= 1'b0;
      data_out_q <= 1'b0;
    end else begin
      if (inst_gnt) begin
        inst_out_q <= 1'b1;
      end else if (inst_ret_valid && r.last) begin
        inst_out_q <= 1'b0;
      end
      if (data_gnt) begin
        data_out_q <= 1'b1;
      end else if (data_ret_valid && r.last) begin
        data_out_q <= 1'b0;
      end
    end
  end

  // steer by rid, no back-pressure on returns
  assign beat           = '{data: r.data, last: r.last};
  assign inst_ret_valid = rvalid && (r.id == ID_INST);
  assign data_ret_valid = rvalid && (r.id == ID_DATA);
  assign inst_ret       = beat;
  assign data_ret       = beat;

  r_id_outstanding: assert property (
    @(posedge aclk) disable iff (reset)
    rvalid |-> (inst_ret_valid && inst_out_q) || (data_ret_valid && data_out_q)
  );

  // a beat cannot answer an AR that is still waiting in the slot
  r_after_ar: assert property (
    @(posedge aclk) disable iff (reset)
    rvalid && slot_full |-> !(gnt_q[0] && inst_ret_valid) && !(gnt_q[1] && data_ret_valid)
  );

endmodule

// File: design/beat_counter.sv
module beat_counter (
  input  logic       aclk,
  input  logic       reset,
  input  logic       start,
  input  logic [7:0] len,
  input  logic       step,
  output logic       last_beat
);

  logic [7:0] count_q;
  logic [7:0] len_q;

  always_ff @(posedge aclk) begin
    if (reset) begin
      count_q <= 8'd0;
      len_q   <= 8'd0;
    end else if (start) begin
      count_q <= 8'd0;
      len_q   <= len;
    end else if (step) begin
      count_q <= count_q + 8'd1;
    end
  end

  // beat numbers run 0..len
  assign last_beat = (count_q == len_q);

endmodule

// File: design/write_line_buffer.sv
module write_line_buffer (
  input  logic                          aclk,
  input  logic                          reset,
  input  logic                          load,
  input  bridge_pkg::wr_req_t           req,
  input  logic                          shift,
  output logic [bridge_pkg::DATA_W-1:0] word,
  output logic [bridge_pkg::STRB_W-1:0] strb
);
  import bridge_pkg::*;

  logic [DATA_W-1:0] words_q [LINE_WORDS];
  logic [STRB_W-1:0] strb_q;

  always_ff @(posedge aclk) begin
    if (load) begin
      for (int i = 0; i < LINE_WORDS; i++) begin
        words_q[i] <= req.data[i];
      end
    end else if (shift) begin
      // next word moves to the front
      for (int i = 0; i < LINE_WORDS - 1; i++) begin
        words_q[i] <= words_q[i + 1];
      end
    end
  end

  // no byte enabled until a request is loaded
  always_ff @(posedge aclk) begin
    if (reset) begin
      strb_q <= '0;
    end else if (load) begin
      strb_q <= (req.rtype == TYPE_LINE) ? {STRB_W{1'b1}} : req.strb;
    end
  end

  assign word = words_q[0];
  assign strb = strb_q;

endmodule

// File: design/write_fsm.sv
module write_fsm (
  input  logic                          aclk,
  input  logic                          reset,
  input  logic                          wr_req,
  input  bridge_pkg::wr_req_t           wr,
  output logic                          wr_rdy,
  output logic                          write_busy,
  input  logic                          aw_full,
  output logic                          aw_load,
  output bridge_pkg::axi_aw_t           aw_data,
  output logic                          wvalid,
  input  logic                          wready,
  output logic                          wlast,
  output logic [bridge_pkg::DATA_W-1:0] wdata,
  output logic [bridge_pkg::STRB_W-1:0] wstrb,
  input  logic                          bvalid,
  output logic                          bready
);
  import bridge_pkg::*;

  typedef enum logic [1:0] {IDLE, ADDR, DATA, RESP} state_t;

  state_t state_q;
  state_t state_d;
  logic   accept;
  logic   data_phase;
  logic   shift;
  logic   last_beat;

  assign wr_rdy     = (state_q == IDLE);
  assign write_busy = (state_q != IDLE);
  assign accept     = wr_req && wr_rdy;
  assign aw_load    = accept;

  always_comb begin
    aw_data.addr = wr.addr;
    aw_data.len  = burst_len(wr.rtype);
    aw_data.size = burst_size(wr.rtype);
  end

  // first beat goes out as soon as the AW slot has drained
  assign data_phase = (state_q == DATA) || (state_q == ADDR && !aw_full);
  assign wvalid     = data_phase;
  assign shift      = data_phase && wready;
  assign wlast      = data_phase && last_beat;
  assign bready     = (state_q == RESP);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = ADDR;
        end
      end
      ADDR, DATA: begin
        if (shift && last_beat) begin
          state_d = RESP;
        end else if (data_phase) begin
          state_d = DATA;
        end
      end
      RESP: begin
        if (bvalid) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  beat_counter u_beat_counter (
    .aclk      (aclk),
    .reset     (reset),
    .start     (accept),
    .len       (aw_data.len),
    .step      (shift),
    .last_beat (last_beat)
  );

  write_line_buffer u_line_buffer (
    .aclk  (aclk),
    .reset (reset),
    .load  (accept),
    .req   (wr),
    .shift (shift),
    .word  (wdata),
    .strb  (wstrb)
  );

  // memory side only answers after the last W beat
  b_only_in_resp: assert property (
    @(posedge aclk) disable iff (reset)
    bvalid |-> state_q == RESP
  );

endmodule

// File: design/mem_bridge_top.sv
module mem_bridge_top (
  input  logic                aclk,
  input  logic                reset,
  // instruction read port
  input  logic                inst_rd_req,
  input  bridge_pkg::rd_req_t inst_rd,
  output logic                inst_rd_rdy,
  output logic                inst_ret_valid,
  output bridge_pkg::ret_t    inst_ret,
  // data read port
  input  logic                data_rd_req,
  input  bridge_pkg::rd_req_t data_rd,
  output logic                data_rd_rdy,
  output logic                data_ret_valid,
  output bridge_pkg::ret_t    data_ret,
  // data write port
  input  logic                wr_req,
  input  bridge_pkg::wr_req_t wr,
  output logic                wr_rdy,
  // AXI3 master
  output bridge_pkg::axi_ar_t ar,
  output logic                arvalid,
  input  logic                arready,
  input  bridge_pkg::axi_r_t  r,
  input  logic                rvalid,
  output bridge_pkg::axi_aw_t aw,
  output logic                awvalid,
  input  logic                awready,
  output bridge_pkg::axi_w_t  w,
  output logic                wvalid,
  input  logic                wready,
  input  logic                bvalid,
  output logic                bready
);
  import bridge_pkg::*;

  logic              write_busy;
  logic              ar_load;
  axi_ar_t           ar_data;
  logic              aw_load;
  axi_aw_t           aw_data;
  logic              wlast;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;

  read_arbiter u_read_arbiter (
    .aclk           (aclk),
    .reset          (reset),
    .inst_rd_req    (inst_rd_req),
    .data_rd_req    (data_rd_req),
    .inst_rd        (inst_rd),
    .data_rd        (data_rd),
    .inst_rd_rdy    (inst_rd_rdy),
    .data_rd_rdy    (data_rd_rdy),
    .write_busy     (write_busy),
    .slot_full      (arvalid),
    .ar_load        (ar_load),
    .ar_data        (ar_data),
    .rvalid         (rvalid),
    .r              (r),
    .inst_ret_valid (inst_ret_valid),
    .data_ret_valid (data_ret_valid),
    .inst_ret       (inst_ret),
    .data_ret       (data_ret)
  );

  req_slot #(.payload_t(axi_ar_t)) u_ar_slot (
    .aclk      (aclk),
    .reset     (reset),
    .load      (ar_load),
    .load_data (ar_data),
    .ready     (arready),
    .valid     (arvalid),
    .data      (ar)
  );

  write_fsm u_write_fsm (
    .aclk       (aclk),
    .reset      (reset),
    .wr_req     (wr_req),
    .wr         (wr),
    .wr_rdy     (wr_rdy),
    .write_busy (write_busy),
    .aw_full    (awvalid),
    .aw_load    (aw_load),
    .aw_data    (aw_data),
    .wvalid     (wvalid),
    .wready     (wready),
    .wlast      (wlast),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .bvalid     (bvalid),
    .bready     (bready)
  );

  req_slot #(.payload_t(axi_aw_t)) u_aw_slot (
    .aclk      (aclk),
    .reset     (reset),
    .load      (aw_load),
    .load_data (aw_data),
    .ready     (awready),
    .valid     (awvalid),
    .data      (aw)
  );

  assign w = '{data: wdata, strb: wstrb, last: wlast};

endmodule

// File: tb/axi_mem_model.sv
module axi_mem_model (
  input  logic                aclk,
  input  logic                reset,
  input  bridge_pkg::axi_ar_t ar,
  input  logic                arvalid,
  output logic                arready,
  output bridge_pkg::axi_r_t  r,
  output logic                rvalid,
  input  bridge_pkg::axi_aw_t aw,
  input  logic                awvalid,
  output logic                awready,
  input  bridge_pkg::axi_w_t  w,
  input  logic                wvalid,
  output logic                wready,
  output logic                bvalid,
  input  logic                bready,
  output bridge_pkg::axi_ar_t seen_inst_ar,
  output bridge_pkg::axi_ar_t seen_data_ar,
  output bridge_pkg::axi_aw_t seen_aw,
  output int                  err_count
);
  timeunit 1ns;
  timeprecision 1ps;
  import bridge_pkg::*;

  localparam logic [31:0] FILL_OFFSET = 32'h1000_0000;

  logic [31:0] mem [256];
  axi_ar_t     rd_q [$];
  axi_ar_t     head;
  axi_aw_t     aw_q;
  int unsigned rnd = 48270;
  int          r_beat;
  int          w_beat;
  logic        aw_have;
  logic        b_pending;
  logic [7:0]  idx;
  logic        exp_last;

  function automatic int unsigned lcg_next(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // ready or valid about three cycles in four
  function automatic logic chance();
    rnd = lcg_next(rnd);
    return rnd[17:16] != 2'b00;
  endfunction

  always @(posedge aclk) begin
    if (reset) begin
      for (int i = 0; i < 256; i++) begin
        mem[i] = FILL_OFFSET + 32'(i * 4);
      end
      rd_q.delete();
      r_beat = 0;
      w_beat = 0;
      aw_have = 1'b0;
      b_pending = 1'b0;
      err_count = 0;
      seen_inst_ar = '0;
      seen_data_ar = '0;
      seen_aw = '0;
    end else begin
      if (arvalid && arready) begin
        rd_q.push_back(ar);
        if (ar.id == ID_INST) begin
          seen_inst_ar = ar;
        end else begin
          seen_data_ar = ar;
        end
      end
      if (rvalid) begin
        if (r.last) begin
          void'(rd_q.pop_front());
          r_beat = 0;
        end else begin
          r_beat++;
        end
      end
      if (awvalid && awready) begin
        aw_q = aw;
        seen_aw = aw;
        aw_have = 1'b1;
        w_beat = 0;
      end
      if (wvalid && wready) begin
        if (!aw_have) begin
          $display("model: W beat arrived with no write address at %0t", $time);
          err_count++;
        end
        idx = aw_q.addr[9:2] + w_beat[7:0];
        for (int b = 0; b < 4; b++) begin
          if (w.strb[b]) begin
            mem[idx][8*b +: 8] = w.data[8*b +: 8];
          end
        end
        exp_last = (w_beat == int'(aw_q.len));
        if (w.last !== exp_last) begin
          $display("FAILED time %0t signal wlast expected %b actual %b", $time, exp_last, w.last);
          err_count++;
        end
        w_beat++;
        if (w.last) begin
          b_pending = 1'b1;
        end
      end
      if (bvalid && bready) begin
        b_pending = 1'b0;
        aw_have = 1'b0;
      end
    end
  end

  // bus stays idle until the first falling edge
  initial begin
    arready = 1'b0;
    awready = 1'b0;
    wready = 1'b0;
    rvalid = 1'b0;
    bvalid = 1'b0;
    r = '0;
    forever begin
      @(negedge aclk);
      if (reset) begin
        arready = 1'b0;
        awready = 1'b0;
        wready = 1'b0;
        rvalid = 1'b0;
        bvalid = 1'b0;
        r = '0;
      end else begin
        arready = chance();
        awready = chance();
        wready = chance();
        // answer reads strictly in AR order
        if (rd_q.size() != 0 && chance()) begin
          head = rd_q[0];
          rvalid = 1'b1;
          r.id = head.id;
          r.data = mem[head.addr[9:2] + r_beat[7:0]];
          r.last = (r_beat == int'(head.len));
        end else begin
          rvalid = 1'b0;
        end
        bvalid = b_pending && chance();
      end
    end
  end

endmodule

// File: tb/tb_top.sv
module tb_top;
  timeunit 1ns;
  timeprecision 1ps;
  import bridge_pkg::*;

  localparam int N_REC      = 15;
  localparam int CLK_PERIOD = 8;

  logic         aclk;
  logic         reset;
  logic         inst_rd_req, data_rd_req, wr_req;
  rd_req_t      inst_rd, data_rd;
  wr_req_t      wr;
  logic         inst_rd_rdy, data_rd_rdy, wr_rdy;
  logic         inst_ret_valid, data_ret_valid;
  ret_t         inst_ret, data_ret;
  axi_ar_t      ar, seen_inst_ar, seen_data_ar;
  axi_aw_t      aw, seen_aw;
  axi_r_t       r;
  axi_w_t       w;
  logic         arvalid, arready, rvalid, awvalid, awready;
  logic         wvalid, wready, bvalid, bready;
  int           model_errors;
  logic [303:0] recs [N_REC];
  ret_t         inst_q [$];
  ret_t         data_q [$];
  int           errors;
  int           checks;

  mem_bridge_top u_dut (.*);

  axi_mem_model u_mem (
    .aclk(aclk), .reset(reset), .ar(ar), .arvalid(arvalid), .arready(arready),
    .r(r), .rvalid(rvalid), .aw(aw), .awvalid(awvalid), .awready(awready),
    .w(w), .wvalid(wvalid), .wready(wready), .bvalid(bvalid), .bready(bready),
    .seen_inst_ar(seen_inst_ar), .seen_data_ar(seen_data_ar), .seen_aw(seen_aw),
    .err_count(model_errors)
  );

  initial begin
    aclk = 1'b0;
    forever #(CLK_PERIOD / 2) aclk = ~aclk;
  end

  always @(posedge aclk) begin
    if (inst_ret_valid) inst_q.push_back(inst_ret);
    if (data_ret_valid) data_q.push_back(data_ret);
  end

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      $display("FAILED time %0t signal %s expected %h actual %h", $time, name, exp_v, act_v);
    end
  endtask

  // burst shape expected for each request type
  function automatic int beats_of(input logic [2:0] t);
    return (t == 3'd4) ? 4 : 1;
  endfunction

  function automatic logic [31:0] size_of(input logic [2:0] t);
    return (t == 3'd0) ? 0 : (t == 3'd1) ? 1 : 2;
  endfunction

  task automatic run_op(input logic [303:0] rec);
    logic [3:0]  port;
    logic [31:0] addr;
    logic [2:0]  rtype;
    logic [3:0]  strb;
    logic [31:0] d [4];
    logic [31:0] e [4];
    int          n;
    ret_t        beat;
    axi_ar_t     seen;
    port = rec[303:300];
    addr = rec[295:264];
    rtype = rec[262:260];
    strb = rec[259:256];
    for (int i = 0; i < 4; i++) begin
      d[i] = rec[255 - 32*i -: 32];
      e[i] = rec[127 - 32*i -: 32];
    end
    n = beats_of(rtype);
    if (port == 4'd2) begin
      @(negedge aclk);
      wr_req = 1'b1;
      wr.addr = addr;
      wr.rtype = rtype;
      wr.strb = strb;
      for (int i = 0; i < 4; i++) wr.data[i] = d[i];
      @(posedge aclk);
      while (!wr_rdy) @(posedge aclk);
      @(negedge aclk);
      wr_req = 1'b0;
      @(posedge aclk);
      while (!wr_rdy) @(posedge aclk);
      check_val("awaddr", addr, seen_aw.addr);
      check_val("awlen", 32'(n - 1), 32'(seen_aw.len));
      check_val("awsize", size_of(rtype), 32'(seen_aw.size));
    end else begin
      @(negedge aclk);
      if (port == 4'd0) begin
        inst_rd_req = 1'b1;
        inst_rd = '{addr: addr, rtype: rtype};
      end else begin
        data_rd_req = 1'b1;
        data_rd = '{addr: addr, rtype: rtype};
      end
      @(posedge aclk);
      while (port == 4'd0 ? !inst_rd_rdy : !data_rd_rdy) @(posedge aclk);
      @(negedge aclk);
      if (port == 4'd0) inst_rd_req = 1'b0;
      else data_rd_req = 1'b0;
      while ((port == 4'd0 ? inst_q.size() : data_q.size()) < n) @(posedge aclk);
      for (int i = 0; i < n; i++) begin
        if (port == 4'd0) beat = inst_q.pop_front();
        else beat = data_q.pop_front();
        check_val(port == 4'd0 ? "inst_ret.data" : "data_ret.data", e[i], beat.data);
        check_val(port == 4'd0 ? "inst_ret.last" : "data_ret.last", 32'(i == n - 1),
                  32'(beat.last));
      end
      seen = (port == 4'd0) ? seen_inst_ar : seen_data_ar;
      check_val("arid", (port == 4'd0) ? 0 : 1, 32'(seen.id));
      check_val("araddr", addr, seen.addr);
      check_val("arlen", 32'(n - 1), 32'(seen.len));
      check_val("arsize", size_of(rtype), 32'(seen.size));
    end
  endtask

  initial begin
    int i;
    errors = 0;
    checks = 0;
    reset = 1'b1;
    inst_rd_req = 1'b0;
    data_rd_req = 1'b0;
    wr_req = 1'b0;
    inst_rd = '0;
    data_rd = '0;
    wr = '0;
    $readmemh("tb/bridge_testdata.txt", recs);
    repeat (8) @(posedge aclk);
    @(negedge aclk);
    reset = 1'b0;
    @(posedge aclk);
    @(negedge aclk);
    check_val("inst_rd_rdy", 1, 32'(inst_rd_rdy));
    check_val("data_rd_rdy", 1, 32'(data_rd_rdy));
    check_val("wr_rdy", 1, 32'(wr_rdy));
    check_val("arvalid", 0, 32'(arvalid));
    check_val("awvalid", 0, 32'(awvalid));
    check_val("wvalid", 0, 32'(wvalid));
    check_val("bready", 0, 32'(bready));
    check_val("inst_ret_valid", 0, 32'(inst_ret_valid));
    check_val("data_ret_valid", 0, 32'(data_ret_valid));
    i = 0;
    while (i < N_REC) begin
      // pair flag set means run alongside the next record
      if (recs[i][299:296] != 4'd0 && i + 1 < N_REC) begin
        fork
          run_op(recs[i]);
          run_op(recs[i + 1]);
        join
        i += 2;
      end else begin
        run_op(recs[i]);
        i++;
      end
    end
    repeat (4) @(posedge aclk);
    if (inst_q.size() != 0 || data_q.size() != 0) begin
      errors++;
      $display("extra return beats arrived on a port that had no read waiting");
    end
    $display("checks %0d, errors %0d, memory model errors %0d", checks, errors, model_errors);
    if (errors == 0 && model_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    #(N_REC * 200 * CLK_PERIOD);
    $display("timeout: operations did not finish within %0d cycles", N_REC * 200);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: tb/bridge_testdata.txt
// port(0 inst rd, 1 data rd, 2 write) pair addr type strb wdata0..3 expect0..3
// pair 1 runs the record together with the next one, memory word = address + 10000000
0_0_00000040_4_0_00000000_00000000_00000000_00000000_10000040_10000044_10000048_1000004c
1_0_00000085_0_0_00000000_00000000_00000000_00000000_10000084_00000000_00000000_00000000
1_0_00000102_1_0_00000000_00000000_00000000_00000000_10000100_00000000_00000000_00000000
1_0_00000200_2_0_00000000_00000000_00000000_00000000_10000200_00000000_00000000_00000000
2_0_00000300_4_0_deadbeef_01234567_89abcdef_cafef00d_00000000_00000000_00000000_00000000
1_0_00000300_4_0_00000000_00000000_00000000_00000000_deadbeef_01234567_89abcdef_cafef00d
2_0_00000180_2_5_aabbccdd_00000000_00000000_00000000_00000000_00000000_00000000_00000000
1_0_00000180_2_0_00000000_00000000_00000000_00000000_10bb01dd_00000000_00000000_00000000
0_1_000003c0_4_0_00000000_00000000_00000000_00000000_100003c0_100003c4_100003c8_100003cc
1_0_00000020_2_0_00000000_00000000_00000000_00000000_10000020_00000000_00000000_00000000
0_1_00000300_4_0_00000000_00000000_00000000_00000000_deadbeef_01234567_89abcdef_cafef00d
1_0_00000010_4_0_00000000_00000000_00000000_00000000_10000010_10000014_10000018_1000001c
2_0_0000000c_0_2_00007700_00000000_00000000_00000000_00000000_00000000_00000000_00000000
1_0_0000000c_2_0_00000000_00000000_00000000_00000000_1000770c_00000000_00000000_00000000
0_0_0000000c_2_0_00000000_00000000_00000000_00000000_1000770c_00000000_00000000_00000000

// File: flist.f
design/bridge_pkg.sv
design/req_slot.sv
design/read_arbiter.sv
design/beat_counter.sv
design/write_line_buffer.sv
design/write_fsm.sv
design/mem_bridge_top.sv
tb/axi_mem_model.sv
tb/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f flist.f --top-module tb_top \
  -Mdir obj_dir -o tb_top_sim || exit 1
./obj_dir/tb_top_sim > sim.log 2>&1 || true
cat sim.log
grep -q "^TESTBENCH PASSED$" sim.log && exit 0 || exit 1
